//--- vlog.f
logic/cpuPkg.sv
logic/ctrlIf.sv
logic/controlFsm.sv
logic/aluDatapath.sv
logic/pcSequencer.sv
logic/regWriteback.sv
logic/mipsCore.sv
bench/tbMem.sv
bench/tbMipsCore.sv

//--- run.sh
#!/bin/sh
# compile and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tbMipsCore -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1

//--- bench/tbMipsCore.sv
// testbench for the multi-cycle core with fetch and store checks and a watchdog
`timescale 1ns/1ps

module tbMipsCore;

  localparam int INSTR_COUNT = 20;   // words in the test program
  localparam int WATCHDOG_NS = (INSTR_COUNT * 5 + 50) * 4;

  logic          clk;
  logic          reset;
  cpuPkg::word_t memReadData;
  cpuPkg::word_t memAddr;
  cpuPkg::word_t memWriteData;
  logic          memWrite;
  cpuPkg::word_t pc;

  cpuPkg::word_t lcgState = 32'hc06aeef3;
  cpuPkg::word_t expNext [32];
  int            expCycles [32];
  int            progLen = 0;
  cpuPkg::word_t expAddr [$];
  cpuPkg::word_t expData [$];
  int            expTest [$];
  int            errs [5] = '{default: 0};
  string         testName [5] = '{"reset", "arithmetic", "load/store", "branch", "jump/timing"};
  int            cycle = 0;
  int            fetchCount = 0;
  int            lastCycle = 0;
  cpuPkg::word_t lastAddr = '0;
  cpuPkg::word_t fetchWant;
  int            fetchTest;
  logic          done = 1'b0;

  mipsCore u_dut (
    .clk(clk), .reset(reset), .memReadData(memReadData), .memAddr(memAddr),
    .memWriteData(memWriteData), .memWrite(memWrite), .pc(pc)
  );

  tbMem u_mem (
    .clk(clk), .addr(memAddr), .writeData(memWriteData), .write(memWrite),
    .readData(memReadData)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic cpuPkg::word_t nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic cpuPkg::word_t rType(cpuPkg::funct_t fn, cpuPkg::regAddr_t d,
                                          cpuPkg::regAddr_t s, cpuPkg::regAddr_t t);
    return {cpuPkg::OP_RTYPE, s, t, d, 5'd0, fn};
  endfunction

  function automatic cpuPkg::word_t iType(cpuPkg::opcode_t op, cpuPkg::regAddr_t s,
                                          cpuPkg::regAddr_t t, cpuPkg::imm_t imm);
    return {op, s, t, imm};
  endfunction

  function automatic cpuPkg::word_t signExtend(cpuPkg::imm_t imm);
    return int'($signed(imm));
  endfunction

  // skip counts words passed over after this one
  task automatic emit(input cpuPkg::word_t w, input int cycles, input int skip);
    u_mem.loadWord(progLen, w);
    expCycles[progLen] = cycles;
    expNext[progLen]   = cpuPkg::word_t'((progLen + 1 + skip) * 4);
    progLen++;
  endtask

  task automatic expectStore(input int test, input cpuPkg::word_t a, input cpuPkg::word_t d);
    expTest.push_back(test);
    expAddr.push_back(a);
    expData.push_back(d);
  endtask

  task automatic noteMismatch(input int test, input string name,
                              input cpuPkg::word_t got, input cpuPkg::word_t exp);
    errs[test]++;
    $display("CHECK FAILED %s got %h expected %h", name, got, exp);
  endtask

  task automatic noteProblem(input int test, input string what);
    errs[test]++;
    $display("%s", what);
  endtask

  always @(posedge clk)
    cycle <= cycle + 1;

  // fetch monitor sampled mid-cycle on the falling edge
  always @(negedge clk)
  begin
    if (!reset && !done && u_dut.u_controlFsm.state == cpuPkg::S_FETCH)
    begin
      fetchWant = (fetchCount == 0) ? '0 : expNext[lastAddr[6:2]];
      fetchTest = (lastAddr[6:2] == 5'd13 || lastAddr[6:2] == 5'd15) ? 3 : 4;
      if (fetchCount == 0)
        fetchTest = 0;
      assert (memAddr == fetchWant)
        else noteMismatch(fetchTest, "memAddr at fetch", memAddr, fetchWant);
      assert (pc == fetchWant)
        else noteMismatch(fetchTest, "pc at fetch", pc, fetchWant);
      if (fetchCount != 0)
      begin
        assert (cycle - lastCycle == expCycles[lastAddr[6:2]])
          else noteMismatch(4, "cycles per instruction", cpuPkg::word_t'(cycle - lastCycle),
                            cpuPkg::word_t'(expCycles[lastAddr[6:2]]));
        if (memAddr == lastAddr)
          done <= 1'b1;   // jump to itself
      end
      lastAddr  <= memAddr;
      lastCycle <= cycle;
      fetchCount <= fetchCount + 1;
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the program reached its final jump");
    $display("Done: errors found");
    $finish;
  end

  initial
  begin
    cpuPkg::word_t r1;
    cpuPkg::word_t r2;
    cpuPkg::word_t placed;
    cpuPkg::word_t rnd;
    cpuPkg::imm_t  imm1;
    cpuPkg::imm_t  imm2;
    int            total;
    int            failed;
    reset = 1'b1;
    u_mem.clear();
    rnd  = nextRandom();
    imm1 = rnd[23:8];
    rnd  = nextRandom();
    imm2 = rnd[23:8];
    if (imm2 == imm1)
      imm2 = imm2 ^ 16'h0001;   // beq fall-through needs unequal registers
    placed = nextRandom();
    u_mem.loadWord(60, placed);   // byte address 240
    r1 = signExtend(imm1);
    r2 = signExtend(imm2);
    emit(iType(cpuPkg::OP_ADDI, 5'd0, 5'd1, imm1), 4, 0);
    emit(iType(cpuPkg::OP_ADDI, 5'd0, 5'd2, imm2), 4, 0);
    emit(iType(cpuPkg::OP_ADDI, 5'd0, 5'd8, 16'd256), 4, 0);
    emit(rType(cpuPkg::FN_ADD, 5'd3, 5'd1, 5'd2), 4, 0);
    emit(rType(cpuPkg::FN_SUB, 5'd4, 5'd1, 5'd2), 4, 0);
    emit(rType(cpuPkg::FN_AND, 5'd5, 5'd1, 5'd2), 4, 0);
    emit(rType(cpuPkg::FN_OR, 5'd6, 5'd1, 5'd2), 4, 0);
    emit(iType(cpuPkg::OP_SW, 5'd0, 5'd3, 16'd192), 4, 0);
    emit(iType(cpuPkg::OP_SW, 5'd0, 5'd4, 16'd196), 4, 0);
    emit(iType(cpuPkg::OP_SW, 5'd0, 5'd5, 16'd200), 4, 0);
    emit(iType(cpuPkg::OP_SW, 5'd8, 5'd6, 16'hffcc), 4, 0);   // 256 - 52
    emit(iType(cpuPkg::OP_LW, 5'd0, 5'd7, 16'd240), 5, 0);
    emit(iType(cpuPkg::OP_SW, 5'd0, 5'd7, 16'd208), 4, 0);
    emit(iType(cpuPkg::OP_BEQ, 5'd1, 5'd1, 16'd1), 3, 1);
    emit(iType(cpuPkg::OP_SW, 5'd0, 5'd1, 16'd212), 4, 0);
    emit(iType(cpuPkg::OP_BEQ, 5'd1, 5'd2, 16'd1), 3, 0);
    emit(iType(cpuPkg::OP_SW, 5'd0, 5'd2, 16'd216), 4, 0);
    emit({cpuPkg::OP_J, 26'(progLen + 2)}, 3, 1);
    emit(iType(cpuPkg::OP_SW, 5'd0, 5'd1, 16'd220), 4, 0);
    emit({cpuPkg::OP_J, 26'(progLen)}, 3, -1);
    expectStore(1, 32'd192, r1 + r2);
    expectStore(1, 32'd196, r1 - r2);
    expectStore(1, 32'd200, r1 & r2);
    expectStore(1, 32'd204, r1 | r2);
    expectStore(2, 32'd208, placed);
    expectStore(3, 32'd216, r2);

    repeat (3)
    begin
      @(negedge clk);
      assert (memWrite == 1'b0) else noteMismatch(0, "memWrite in reset", {31'd0, memWrite}, '0);
    end
    reset = 1'b0;
    @(negedge clk);
    assert (memWrite == 1'b0) else noteMismatch(0, "memWrite after reset", {31'd0, memWrite}, '0);

    wait (done);
    assert (u_mem.storeAddr.size() == expAddr.size())
      else noteProblem(1, "the number of stores differs from the program's store count");
    for (int i = 0; i < expAddr.size() && i < u_mem.storeAddr.size(); i++)
    begin
      assert (u_mem.storeAddr[i] == expAddr[i])
        else noteMismatch(expTest[i], "memAddr of store", u_mem.storeAddr[i], expAddr[i]);
      assert (u_mem.storeData[i] == expData[i])
        else noteMismatch(expTest[i], "memWriteData of store", u_mem.storeData[i], expData[i]);
    end
    foreach (u_mem.storeAddr[i])
    begin
      assert (u_mem.storeAddr[i] != 32'd212)
        else noteProblem(3, "the store after the taken beq was executed");
      assert (u_mem.storeAddr[i] != 32'd220)
        else noteProblem(4, "the store after the jump was executed");
    end

    total  = 0;
    failed = 0;
    for (int t = 0; t < 5; t++)
    begin
      $display("test %-12s %s (%0d errors)", testName[t], errs[t] == 0 ? "ok" : "FAILED", errs[t]);
      total += errs[t];
      if (errs[t] != 0)
        failed++;
    end
    $display("tests run 5, tests failed %0d, errors %0d", failed, total);
    if (total == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

//--- bench/tbMem.sv
// testbench memory holding the 64-word program and data store and recording every store
`timescale 1ns/1ps

module tbMem (
  input  logic          clk,
  input  cpuPkg::word_t addr,
  input  cpuPkg::word_t writeData,
  input  logic          write,
  output cpuPkg::word_t readData
);

  cpuPkg::word_t mem [64];
  cpuPkg::word_t storeAddr [$];   // one entry per store in order
  cpuPkg::word_t storeData [$];

  assign readData = mem[addr[7:2]];   // combinational read

  always @(posedge clk)
  begin
    if (write)
    begin
      mem[addr[7:2]] = writeData;
      storeAddr.push_back(addr);
      storeData.push_back(writeData);
    end
  end

  // every word gets a pattern built from its own byte address
  task automatic clear();
    for (int i = 0; i < 64; i++)
      mem[i] = 32'hfeed0000 | (i << 2);
  endtask

  task automatic loadWord(input int idx, input cpuPkg::word_t w);
    mem[idx] = w;
  endtask

endmodule

//--- logic/mipsCore.sv
// multi-cycle mips core joining the control FSM, datapath and register file on one memory bus
`timescale 1ns/1ps

module mipsCore (
  input  logic          clk,
  input  logic          reset,
  input  cpuPkg::word_t memReadData,
  output cpuPkg::word_t memAddr,
  output cpuPkg::word_t memWriteData,
  output logic          memWrite,
  output cpuPkg::word_t pc
);

  cpuPkg::opcode_t  opcode;
  cpuPkg::funct_t   funct;
  cpuPkg::regAddr_t rs;
  cpuPkg::regAddr_t rt;
  cpuPkg::regAddr_t rd;
  cpuPkg::word_t    aluResult;
  cpuPkg::word_t    aluOut;
  cpuPkg::word_t    readData1;
  cpuPkg::word_t    readData2;
  cpuPkg::word_t    regB;
  logic [25:0]      jumpField;
  logic             zero;

  ctrlIf ctrlBus ();

  controlFsm u_controlFsm (
    .clk(clk), .reset(reset), .opcode(opcode), .funct(funct), .ctrl(ctrlBus.fsm)
  );

  aluDatapath u_aluDatapath (
    .clk(clk), .reset(reset), .ctrl(ctrlBus.exec), .memReadData(memReadData),
    .pc(pc), .readData1(readData1), .readData2(readData2),
    .opcode(opcode), .funct(funct), .rs(rs), .rt(rt), .rd(rd),
    .jumpField(jumpField), .aluResult(aluResult), .aluOut(aluOut),
    .zero(zero), .regB(regB)
  );

  pcSequencer u_pcSequencer (
    .clk(clk), .reset(reset), .ctrl(ctrlBus.seq), .aluResult(aluResult),
    .aluOut(aluOut), .zero(zero), .jumpField(jumpField), .pc(pc), .memAddr(memAddr)
  );

  regWriteback u_regWriteback (
    .clk(clk), .reset(reset), .ctrl(ctrlBus.wb), .memReadData(memReadData),
    .aluOut(aluOut), .rs(rs), .rt(rt), .rd(rd),
    .readData1(readData1), .readData2(readData2)
  );

  assign memWrite     = ctrlBus.memWrite;
  assign memWriteData = regB;   // rt value held in B

endmodule

//--- logic/regWriteback.sv
// register file with memory data register and writeback selection
`timescale 1ns/1ps

module regWriteback (
  input  logic             clk,
  input  logic             reset,
  ctrlIf.wb                ctrl,
  input  cpuPkg::word_t    memReadData,
  input  cpuPkg::word_t    aluOut,
  input  cpuPkg::regAddr_t rs,
  input  cpuPkg::regAddr_t rt,
  input  cpuPkg::regAddr_t rd,
  output cpuPkg::word_t    readData1,
  output cpuPkg::word_t    readData2
);

  cpuPkg::word_t    regFile [cpuPkg::REG_COUNT];
  cpuPkg::word_t    mdr;
  cpuPkg::word_t    writeData;
  cpuPkg::regAddr_t writeAddr;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      mdr <= '0;
    else
      mdr <= memReadData;   // sampled every cycle
  end

  assign writeAddr = ctrl.regDst ? rd : rt;
  assign writeData = ctrl.memToReg ? mdr : aluOut;

  always_ff @(posedge clk)
  begin
    if (ctrl.regWrite)
      regFile[writeAddr] <= writeData;
  end

  // register 0 is hardwired to zero
  assign readData1 = (rs == '0) ? '0 : regFile[rs];
  assign readData2 = (rt == '0) ? '0 : regFile[rt];

endmodule

//--- logic/pcSequencer.sv
// pc sequencer holding the program counter, next-pc choice, branch decision and memory address
`timescale 1ns/1ps

module pcSequencer (
  input  logic          clk,
  input  logic          reset,
  ctrlIf.seq            ctrl,
  input  cpuPkg::word_t aluResult,
  input  cpuPkg::word_t aluOut,
  input  logic          zero,
  input  logic [25:0]   jumpField,
  output cpuPkg::word_t pc,
  output cpuPkg::word_t memAddr
);

  cpuPkg::word_t nextPc;
  cpuPkg::word_t jumpTarget;
  logic          pcLoad;

  // pc already points past the jump here
  assign jumpTarget = {pc[31:28], jumpField, 2'b00};

  always_comb
  begin
    case (ctrl.pcSource)
      cpuPkg::PCSRC_ALUOUT: nextPc = aluOut;       // branch target from decode
      cpuPkg::PCSRC_JUMP:   nextPc = jumpTarget;
      default:              nextPc = aluResult;
    endcase
  end

  assign pcLoad = ctrl.pcWrite | (ctrl.branch & zero);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      pc <= '0;
    else if (pcLoad)
      pc <= nextPc;
  end

  assign memAddr = ctrl.iorD ? aluOut : pc;

endmodule

//--- logic/aluDatapath.sv
// execute datapath with the instruction and operand registers, ALU and result register
`timescale 1ns/1ps

module aluDatapath (
  input  logic             clk,
  input  logic             reset,
  ctrlIf.exec              ctrl,
  input  cpuPkg::word_t    memReadData,
  input  cpuPkg::word_t    pc,
  input  cpuPkg::word_t    readData1,
  input  cpuPkg::word_t    readData2,
  output cpuPkg::opcode_t  opcode,
  output cpuPkg::funct_t   funct,
  output cpuPkg::regAddr_t rs,
  output cpuPkg::regAddr_t rt,
  output cpuPkg::regAddr_t rd,
  output logic [25:0]      jumpField,
  output cpuPkg::word_t    aluResult,
  output cpuPkg::word_t    aluOut,
  output logic             zero,
  output cpuPkg::word_t    regB
);

  cpuPkg::word_t instr;
  cpuPkg::word_t regA;
  cpuPkg::word_t signExt;
  cpuPkg::word_t aluA;
  cpuPkg::word_t aluB;
  cpuPkg::imm_t  imm;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      instr  <= '0;
      regA   <= '0;
      regB   <= '0;
      aluOut <= '0;
    end
    else
    begin
      if (ctrl.irWrite)
        instr <= memReadData;
      regA   <= readData1;   // operands reload every cycle
      regB   <= readData2;
      aluOut <= aluResult;
    end
  end

  // instruction fields
  assign opcode    = instr[31:26];
  assign rs        = instr[25:21];
  assign rt        = instr[20:16];
  assign rd        = instr[15:11];
  assign funct     = instr[5:0];
  assign jumpField = instr[25:0];
  assign imm       = instr[15:0];

  assign signExt = {{16{imm[15]}}, imm};

  assign aluA = ctrl.aluSrcA ? regA : pc;

  always_comb
  begin
    case (ctrl.aluSrcB)
      cpuPkg::SRCB_FOUR:   aluB = cpuPkg::PC_STEP;
      cpuPkg::SRCB_IMM:    aluB = signExt;
      cpuPkg::SRCB_BRANCH: aluB = {signExt[29:0], 2'b00};  // word offset
      default:             aluB = regB;
    endcase
  end

  always_comb
  begin
    case (ctrl.aluOp)
      cpuPkg::ALU_SUB: aluResult = aluA - aluB;
      cpuPkg::ALU_AND: aluResult = aluA & aluB;
      cpuPkg::ALU_OR:  aluResult = aluA | aluB;
      default:         aluResult = aluA + aluB;
    endcase
  end

  assign zero = (aluResult == '0);

endmodule

//--- logic/controlFsm.sv
// control FSM that sequences the multi-cycle steps and decodes the ALU operation
`timescale 1ns/1ps

module controlFsm (
  input  logic            clk,
  input  logic            reset,
  input  cpuPkg::opcode_t opcode,
  input  cpuPkg::funct_t  funct,
  ctrlIf.fsm              ctrl
);

  cpuPkg::state_e state;
  cpuPkg::state_e nextState;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      state <= cpuPkg::S_RESET;
    else
      state <= nextState;
  end

  always_comb
  begin
    nextState = cpuPkg::S_FETCH;   // most states go back to fetch
    case (state)
      cpuPkg::S_RESET:   nextState = cpuPkg::S_FETCH;
      cpuPkg::S_FETCH:   nextState = cpuPkg::S_DECODE;
      cpuPkg::S_DECODE:
      begin
        case (opcode)
          cpuPkg::OP_RTYPE: nextState = cpuPkg::S_EXEC;
          cpuPkg::OP_J:     nextState = cpuPkg::S_JUMP;
          cpuPkg::OP_BEQ:   nextState = cpuPkg::S_BRANCH;
          cpuPkg::OP_ADDI,
          cpuPkg::OP_LW,
          cpuPkg::OP_SW:    nextState = cpuPkg::S_MEMADDR;
          default:          nextState = cpuPkg::S_FETCH;  // unknown op
        endcase
      end
      cpuPkg::S_MEMADDR:
      begin
        case (opcode)
          cpuPkg::OP_LW:   nextState = cpuPkg::S_MEMREAD;
          cpuPkg::OP_SW:   nextState = cpuPkg::S_STORE;
          cpuPkg::OP_ADDI: nextState = cpuPkg::S_ADDIWB;
          default:         nextState = cpuPkg::S_FETCH;
        endcase
      end
      cpuPkg::S_MEMREAD: nextState = cpuPkg::S_LOADWB;
      cpuPkg::S_EXEC:    nextState = cpuPkg::S_RTYPEWB;
      default:           nextState = cpuPkg::S_FETCH;
    endcase
  end

  // strobes are pure functions of the state
  always_comb
  begin
    ctrl.pcWrite  = 1'b0;
    ctrl.branch   = 1'b0;
    ctrl.pcSource = cpuPkg::PCSRC_ALU;
    ctrl.iorD     = 1'b0;
    ctrl.memWrite = 1'b0;
    ctrl.irWrite  = 1'b0;
    ctrl.memToReg = 1'b0;
    ctrl.regWrite = 1'b0;
    ctrl.regDst   = 1'b0;
    ctrl.aluSrcA  = 1'b0;
    ctrl.aluSrcB  = cpuPkg::SRCB_REG;
    case (state)
      cpuPkg::S_FETCH:
      begin
        ctrl.irWrite = 1'b1;
        ctrl.pcWrite = 1'b1;                // pc <= pc + 4
        ctrl.aluSrcB = cpuPkg::SRCB_FOUR;
      end
      cpuPkg::S_DECODE:  ctrl.aluSrcB = cpuPkg::SRCB_BRANCH;  // branch target into aluOut
      cpuPkg::S_MEMADDR,
      cpuPkg::S_MEMREAD:
      begin
        ctrl.aluSrcA = 1'b1;
        ctrl.aluSrcB = cpuPkg::SRCB_IMM;   // hold the address in aluOut
        ctrl.iorD    = (state == cpuPkg::S_MEMREAD);
      end
      cpuPkg::S_LOADWB:
      begin
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      cpuPkg::S_STORE:
      begin
        ctrl.iorD     = 1'b1;
        ctrl.memWrite = 1'b1;
      end
      cpuPkg::S_EXEC:    ctrl.aluSrcA = 1'b1;
      cpuPkg::S_RTYPEWB:
      begin
        ctrl.aluSrcA  = 1'b1;
        ctrl.regDst   = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      cpuPkg::S_BRANCH:
      begin
        ctrl.aluSrcA  = 1'b1;
        ctrl.branch   = 1'b1;
        ctrl.pcSource = cpuPkg::PCSRC_ALUOUT;
      end
      cpuPkg::S_JUMP:
      begin
        ctrl.pcWrite  = 1'b1;
        ctrl.pcSource = cpuPkg::PCSRC_JUMP;
      end
      cpuPkg::S_ADDIWB:  ctrl.regWrite = 1'b1;   // rt <= aluOut
      default:           ctrl.pcWrite = 1'b0;    // S_RESET keeps all strobes low
    endcase
  end

  // alu operation from funct in r-type states, subtract for beq and add otherwise
  always_comb
  begin
    ctrl.aluOp = cpuPkg::ALU_ADD;
    if (state == cpuPkg::S_BRANCH)
      ctrl.aluOp = cpuPkg::ALU_SUB;
    else if (state == cpuPkg::S_EXEC || state == cpuPkg::S_RTYPEWB)
    begin
      case (funct)
        cpuPkg::FN_SUB: ctrl.aluOp = cpuPkg::ALU_SUB;
        cpuPkg::FN_AND: ctrl.aluOp = cpuPkg::ALU_AND;
        cpuPkg::FN_OR:  ctrl.aluOp = cpuPkg::ALU_OR;
        default:        ctrl.aluOp = cpuPkg::ALU_ADD;
      endcase
    end
  end

endmodule

//--- logic/ctrlIf.sv
// control bus carrying the strobes from the control FSM to the datapath blocks
`timescale 1ns/1ps

interface ctrlIf;
  logic             pcWrite;
  logic             branch;    // conditional pc write on zero
  cpuPkg::pcSrc_e   pcSource;
  logic             iorD;      // 1 selects data address
  logic             memWrite;
  logic             irWrite;
  logic             memToReg;  // 1 writes back memory data
  logic             regWrite;
  logic             regDst;    // 1 selects rd
  logic             aluSrcA;   // 1 selects register A
  cpuPkg::aluSrcB_e aluSrcB;
  cpuPkg::aluOp_e   aluOp;

  modport fsm (output pcWrite, branch, pcSource, iorD, memWrite, irWrite,
               memToReg, regWrite, regDst, aluSrcA, aluSrcB, aluOp);
  modport exec (input irWrite, aluSrcA, aluSrcB, aluOp);
  modport seq (input pcWrite, branch, pcSource, iorD);
  modport wb (input memToReg, regWrite, regDst);
endinterface

//--- logic/cpuPkg.sv
// cpu package with shared widths, instruction fields, encodings and control enums
package cpuPkg;

  typedef logic [31:0] word_t;    // data, address or instruction word
  typedef logic [4:0]  regAddr_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  funct_t;
  typedef logic [15:0] imm_t;

  // primary opcodes
  localparam opcode_t OP_RTYPE = 6'b000000;
  localparam opcode_t OP_J     = 6'b000010;
  localparam opcode_t OP_BEQ   = 6'b000100;
  localparam opcode_t OP_ADDI  = 6'b001000;
  localparam opcode_t OP_LW    = 6'b100011;
  localparam opcode_t OP_SW    = 6'b101011;

  // r-type function codes
  localparam funct_t FN_ADD = 6'b100000;
  localparam funct_t FN_SUB = 6'b100010;
  localparam funct_t FN_AND = 6'b100100;
  localparam funct_t FN_OR  = 6'b100101;

  typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR} aluOp_e;

  typedef enum logic [1:0] {SRCB_REG, SRCB_FOUR, SRCB_IMM, SRCB_BRANCH} aluSrcB_e;

  typedef enum logic [1:0] {PCSRC_ALU, PCSRC_ALUOUT, PCSRC_JUMP} pcSrc_e;

  typedef enum logic [3:0] {
    S_RESET   = 4'd0,
    S_FETCH   = 4'd1,
    S_DECODE  = 4'd2,
    S_MEMADDR = 4'd3,
    S_MEMREAD = 4'd4,
    S_LOADWB  = 4'd5,
    S_STORE   = 4'd6,
    S_EXEC    = 4'd7,
    S_RTYPEWB = 4'd8,
    S_BRANCH  = 4'd9,
    S_JUMP    = 4'd10,
    S_ADDIWB  = 4'd11
  } state_e;

  localparam word_t PC_STEP   = 32'd4;
  localparam int    REG_COUNT = 32;

endpackage
